// ==== src/rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int INST_LEN  = 32;
    localparam int REG_IDX_W = 5;

    // major opcode, taken from instr[6:2]
    typedef enum logic [4:0] {
        OP_LOAD   = 5'b00000,
        OP_IMM    = 5'b00100,
        OP_AUIPC  = 5'b00101,
        OP_IMM_32 = 5'b00110,
        OP_STORE  = 5'b01000,
        OP_REG    = 5'b01100,
        OP_LUI    = 5'b01101,
        OP_REG_32 = 5'b01110,
        OP_BRANCH = 5'b11000,
        OP_JALR   = 5'b11001,
        OP_JAL    = 5'b11011,
        OP_SYSTEM = 5'b11100
    } opcode_e;

    // minor code, instr[14:12]
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SR      = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

    // system opcode shares the same funct3 encodings
    localparam funct3_e F3_ENV   = F3_ADD_SUB;
    localparam funct3_e F3_CSRRW = F3_SLL;
    localparam funct3_e F3_CSRRS = F3_SLT;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_e;

endpackage

// ==== src/rv_ctrl_pkg.sv ====
package rv_ctrl_pkg;

    localparam int XLEN       = 64;
    localparam int ALU_OP_W   = 5;
    localparam int SRC2_SEL_W = 2;
    localparam int DIV_SEL_W  = 3;

    // operations understood by the execute ALU
    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD_64,
        ALU_ADD_32,
        ALU_SUB_64,
        ALU_SUB_32,
        ALU_SLL_64,
        ALU_SLL_32,
        ALU_SRL_64,
        ALU_SRL_32,
        ALU_SRA_64,
        ALU_SRA_32,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        // result is operand 2 unchanged, used by lui
        ALU_SRC2
    } alu_op_e;

    typedef enum logic {
        SRC1_RS1,
        SRC1_PC
    } src1_sel_e;

    typedef enum logic [SRC2_SEL_W-1:0] {
        SRC2_RS2,
        SRC2_IMM,
        SRC2_FOUR,
        SRC2_ZERO
    } src2_sel_e;

    // M-extension op, same order as funct3
    typedef enum logic [DIV_SEL_W-1:0] {
        DIV_MUL,
        DIV_MULH,
        DIV_MULHSU,
        DIV_MULHU,
        DIV_DIV,
        DIV_DIVU,
        DIV_REM,
        DIV_REMU
    } div_sel_e;

endpackage

// ==== src/id_ctrl_if.sv ====
`timescale 1ns/1ps

interface id_ctrl_if;

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    alu_op_e                alu_op;
    src1_sel_e              src1_sel;
    src2_sel_e              src2_sel;
    imm_fmt_e               imm_fmt;
    logic                   is_jal;
    logic                   is_jalr;
    logic                   is_brc;
    logic                   wb_en;
    logic                   div_en;
    div_sel_e               div_sel;
    // trap_in marks ecall, trap_out marks mret
    logic                   trap;
    logic                   trap_in;
    logic                   trap_out;
    logic [REG_IDX_W-1:0]   rd_idx;

    modport prod (
        output alu_op, src1_sel, src2_sel, imm_fmt,
        output is_jal, is_jalr, is_brc, wb_en,
        output div_en, div_sel, trap, trap_in, trap_out, rd_idx
    );

    modport cons (
        input alu_op, src1_sel, src2_sel, imm_fmt,
        input is_jal, is_jalr, is_brc, wb_en,
        input div_en, div_sel, trap, trap_in, trap_out, rd_idx
    );

endinterface

// ==== src/id_decoder.sv ====
`timescale 1ns/1ps

module id_decoder (
    input  logic [rv_isa_pkg::INST_LEN-1:0]  instr_i,
    id_ctrl_if.prod                          ctrl_o,
    output logic [rv_isa_pkg::REG_IDX_W-1:0] rs1_idx_o,
    output logic [rv_isa_pkg::REG_IDX_W-1:0] rs2_idx_o
);

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    opcode_e     opcode;
    funct3_e     funct3;
    logic [6:0]  funct7;

    assign opcode = opcode_e'(instr_i[6:2]);
    assign funct3 = funct3_e'(instr_i[14:12]);
    assign funct7 = instr_i[31:25];

    // shared by register and immediate forms
    // alt is funct7[5], word picks the 32-bit variant
    function automatic alu_op_e alu_map(funct3_e f3, logic alt, logic word, logic sub_ok);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: begin
                if (alt && sub_ok) begin
                    op = word ? ALU_SUB_32 : ALU_SUB_64;
                end else begin
                    op = word ? ALU_ADD_32 : ALU_ADD_64;
                end
            end
            F3_SLL:  op = word ? ALU_SLL_32 : ALU_SLL_64;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR: begin
                if (alt) begin
                    op = word ? ALU_SRA_32 : ALU_SRA_64;
                end else begin
                    op = word ? ALU_SRL_32 : ALU_SRL_64;
                end
            end
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
            default: op = ALU_ADD_64;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl_o.alu_op   = ALU_ADD_64;
        ctrl_o.src1_sel = SRC1_RS1;
        ctrl_o.src2_sel = SRC2_RS2;
        ctrl_o.imm_fmt  = IMM_NONE;
        ctrl_o.is_jal   = 1'b0;
        ctrl_o.is_jalr  = 1'b0;
        ctrl_o.is_brc   = 1'b0;
        ctrl_o.wb_en    = 1'b0;
        ctrl_o.div_en   = 1'b0;
        ctrl_o.div_sel  = DIV_MUL;
        ctrl_o.trap     = 1'b0;
        ctrl_o.trap_in  = 1'b0;
        ctrl_o.trap_out = 1'b0;
        rs1_idx_o       = '0;
        rs2_idx_o       = '0;

        case (opcode)
            OP_REG, OP_REG_32: begin
                ctrl_o.alu_op  = alu_map(funct3, funct7[5], opcode[1], 1'b1);
                ctrl_o.wb_en   = 1'b1;
                // mul/div rides on funct7 = 1
                ctrl_o.div_en  = funct7[0];
                ctrl_o.div_sel = div_sel_e'(instr_i[14:12]);
                rs1_idx_o      = instr_i[19:15];
                rs2_idx_o      = instr_i[24:20];
            end
            OP_IMM, OP_IMM_32: begin
                ctrl_o.alu_op   = alu_map(funct3, funct7[5], opcode[1], 1'b0);
                ctrl_o.src2_sel = SRC2_IMM;
                ctrl_o.imm_fmt  = IMM_I;
                ctrl_o.wb_en    = 1'b1;
                rs1_idx_o       = instr_i[19:15];
            end
            OP_LOAD: begin
                ctrl_o.src2_sel = SRC2_IMM;
                ctrl_o.imm_fmt  = IMM_I;
                // only a full 32-bit encoding writes back
                ctrl_o.wb_en    = &instr_i[1:0];
                rs1_idx_o       = instr_i[19:15];
            end
            OP_STORE: begin
                ctrl_o.src2_sel = SRC2_IMM;
                ctrl_o.imm_fmt  = IMM_S;
                rs1_idx_o       = instr_i[19:15];
                rs2_idx_o       = instr_i[24:20];
            end
            OP_BRANCH: begin
                ctrl_o.is_brc  = 1'b1;
                ctrl_o.imm_fmt = IMM_B;
                rs1_idx_o      = instr_i[19:15];
                rs2_idx_o      = instr_i[24:20];
            end
            OP_JAL, OP_JALR: begin
                // ALU computes the link address pc + 4
                ctrl_o.src1_sel = SRC1_PC;
                ctrl_o.src2_sel = SRC2_FOUR;
                ctrl_o.wb_en    = 1'b1;
                ctrl_o.is_jal   = (opcode == OP_JAL);
                ctrl_o.is_jalr  = (opcode == OP_JALR);
                ctrl_o.imm_fmt  = (opcode == OP_JAL) ? IMM_J : IMM_I;
                rs1_idx_o       = (opcode == OP_JALR) ? instr_i[19:15] : '0;
            end
            OP_LUI: begin
                ctrl_o.alu_op   = ALU_SRC2;
                ctrl_o.src2_sel = SRC2_IMM;
                ctrl_o.imm_fmt  = IMM_U;
                ctrl_o.wb_en    = 1'b1;
            end
            OP_AUIPC: begin
                ctrl_o.src1_sel = SRC1_PC;
                ctrl_o.src2_sel = SRC2_IMM;
                ctrl_o.imm_fmt  = IMM_U;
                ctrl_o.wb_en    = 1'b1;
            end
            OP_SYSTEM: begin
                ctrl_o.src2_sel = SRC2_ZERO;
                rs1_idx_o       = instr_i[19:15];
                case (funct3)
                    F3_ENV: begin
                        // ebreak has bit 20 set and only raises trap
                        ctrl_o.trap     = 1'b1;
                        ctrl_o.trap_in  = ~instr_i[21] & ~instr_i[20];
                        ctrl_o.trap_out = instr_i[21] & ~instr_i[20];
                    end
                    F3_CSRRW, F3_CSRRS: begin
                        ctrl_o.wb_en = 1'b1;
                    end
                    default: begin
                        ctrl_o.wb_en = 1'b0;
                    end
                endcase
            end
            default: begin
                ctrl_o.wb_en = 1'b0;
            end
        endcase

        ctrl_o.rd_idx = ctrl_o.wb_en ? instr_i[11:7] : '0;

        // execute redirects on exactly one kind of control transfer
        jump_onehot_a: assert ($onehot0({ctrl_o.is_jal, ctrl_o.is_jalr, ctrl_o.is_brc}))
            else $error("decoder raised more than one jump/branch flag");
    end

endmodule

// ==== src/id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg #(
    parameter int XLEN = rv_ctrl_pkg::XLEN
) (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            stall_i,
    input  logic                            flush_i,
    input  logic                            instr_valid_i,
    input  logic [XLEN-1:0]                 pc_i,
    input  logic [XLEN-1:0]                 rs1_data_i,
    input  logic [XLEN-1:0]                 rs2_data_i,
    input  logic [rv_isa_pkg::INST_LEN-1:0] instr_i,
    id_ctrl_if.cons                         ctrl_i,
    id_ctrl_if.prod                         ctrl_o,
    output logic                            ex_valid_o,
    output logic [XLEN-1:0]                 ex_pc_o,
    output logic [XLEN-1:0]                 ex_rs1_o,
    output logic [XLEN-1:0]                 ex_rs2_o,
    output logic [rv_isa_pkg::INST_LEN-1:0] ex_instr_o
);

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    // flush beats stall
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ex_valid_o <= 1'b0;
        end else if (flush_i) begin
            ex_valid_o <= 1'b0;
        end else if (!stall_i) begin
            ex_valid_o <= instr_valid_i;
        end
    end

    // control bundle, back to a harmless add on reset
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ctrl_o.alu_op   <= ALU_ADD_64;
            ctrl_o.src1_sel <= SRC1_RS1;
            ctrl_o.src2_sel <= SRC2_RS2;
            ctrl_o.imm_fmt  <= IMM_NONE;
            ctrl_o.is_jal   <= 1'b0;
            ctrl_o.is_jalr  <= 1'b0;
            ctrl_o.is_brc   <= 1'b0;
            ctrl_o.wb_en    <= 1'b0;
            ctrl_o.div_en   <= 1'b0;
            ctrl_o.div_sel  <= DIV_MUL;
            ctrl_o.trap     <= 1'b0;
            ctrl_o.trap_in  <= 1'b0;
            ctrl_o.trap_out <= 1'b0;
            ctrl_o.rd_idx   <= '0;
        end else if (!stall_i) begin
            ctrl_o.alu_op   <= ctrl_i.alu_op;
            ctrl_o.src1_sel <= ctrl_i.src1_sel;
            ctrl_o.src2_sel <= ctrl_i.src2_sel;
            ctrl_o.imm_fmt  <= ctrl_i.imm_fmt;
            ctrl_o.is_jal   <= ctrl_i.is_jal;
            ctrl_o.is_jalr  <= ctrl_i.is_jalr;
            ctrl_o.is_brc   <= ctrl_i.is_brc;
            ctrl_o.wb_en    <= ctrl_i.wb_en;
            ctrl_o.div_en   <= ctrl_i.div_en;
            ctrl_o.div_sel  <= ctrl_i.div_sel;
            ctrl_o.trap     <= ctrl_i.trap;
            ctrl_o.trap_in  <= ctrl_i.trap_in;
            ctrl_o.trap_out <= ctrl_i.trap_out;
            ctrl_o.rd_idx   <= ctrl_i.rd_idx;
        end
    end

    // payload only
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            ex_pc_o    <= pc_i;
            ex_rs1_o   <= rs1_data_i;
            ex_rs2_o   <= rs2_data_i;
            ex_instr_o <= instr_i;
        end
    end

    // a flushed slot never shows up as valid in execute
    flush_kills_valid_a: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> !ex_valid_o
    ) else $error("ex_valid_o high in the cycle after flush_i");

endmodule

// ==== src/ex_operand_unit.sv ====
`timescale 1ns/1ps

module ex_operand_unit #(
    parameter int XLEN = rv_ctrl_pkg::XLEN
) (
    id_ctrl_if.cons                         ctrl_i,
    input  logic [rv_isa_pkg::INST_LEN-1:0] instr_i,
    input  logic [XLEN-1:0]                 pc_i,
    input  logic [XLEN-1:0]                 rs1_i,
    input  logic [XLEN-1:0]                 rs2_i,
    output logic [XLEN-1:0]                 imm_o,
    output logic [XLEN-1:0]                 opnd1_o,
    output logic [XLEN-1:0]                 opnd2_o
);

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic sign;

    // every format takes its sign from bit 31
    assign sign = instr_i[31];

    always_comb begin
        case (ctrl_i.imm_fmt)
            IMM_I: begin
                imm_o = {{(XLEN-12){sign}}, instr_i[31:20]};
            end
            IMM_S: begin
                imm_o = {{(XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};
            end
            IMM_B: begin
                imm_o = {{(XLEN-13){sign}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
            end
            IMM_U: begin
                imm_o = {{(XLEN-32){sign}}, instr_i[31:12], 12'b0};
            end
            IMM_J: begin
                imm_o = {{(XLEN-21){sign}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};
            end
            default: begin
                imm_o = '0;
            end
        endcase

        // registered bundle only ever carries a legal format
        imm_fmt_known_a: assert (!$isunknown(ctrl_i.imm_fmt) && (ctrl_i.imm_fmt <= IMM_J))
            else $error("illegal imm_fmt %0d reached execute", ctrl_i.imm_fmt);
    end

    assign opnd1_o = (ctrl_i.src1_sel == SRC1_PC) ? pc_i : rs1_i;

    always_comb begin
        case (ctrl_i.src2_sel)
            SRC2_RS2:  opnd2_o = rs2_i;
            SRC2_IMM:  opnd2_o = imm_o;
            SRC2_FOUR: opnd2_o = XLEN'(4);
            default:   opnd2_o = '0;
        endcase
    end

endmodule

// ==== src/id_stage_top.sv ====
`timescale 1ns/1ps

module id_stage_top #(
    parameter int XLEN = rv_ctrl_pkg::XLEN
) (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             instr_valid_i,
    input  logic [rv_isa_pkg::INST_LEN-1:0]  instr_i,
    input  logic [XLEN-1:0]                  pc_i,
    input  logic [XLEN-1:0]                  rs1_data_i,
    input  logic [XLEN-1:0]                  rs2_data_i,
    input  logic                             stall_i,
    input  logic                             flush_i,
    output logic [rv_isa_pkg::REG_IDX_W-1:0] rs1_idx_o,
    output logic [rv_isa_pkg::REG_IDX_W-1:0] rs2_idx_o,
    output logic                             ex_valid_o,
    output rv_ctrl_pkg::alu_op_e             alu_op_o,
    output logic [XLEN-1:0]                  opnd1_o,
    output logic [XLEN-1:0]                  opnd2_o,
    output logic [XLEN-1:0]                  imm_o,
    output logic [rv_isa_pkg::REG_IDX_W-1:0] rd_idx_o,
    output logic                             wb_en_o,
    output logic                             is_jal_o,
    output logic                             is_jalr_o,
    output logic                             is_brc_o,
    output logic                             div_en_o,
    output rv_ctrl_pkg::div_sel_e            div_sel_o,
    output logic                             trap_o,
    output logic                             trap_in_o,
    output logic                             trap_out_o
);

    logic [XLEN-1:0]                 ex_pc;
    logic [XLEN-1:0]                 ex_rs1;
    logic [XLEN-1:0]                 ex_rs2;
    logic [rv_isa_pkg::INST_LEN-1:0] ex_instr;

    // decode side and execute side of the bundle
    id_ctrl_if dec_ctrl ();
    id_ctrl_if ex_ctrl ();

    // register indices leave combinationally for the outside register file
    id_decoder i_id_decoder (
        .instr_i   (instr_i),
        .ctrl_o    (dec_ctrl),
        .rs1_idx_o (rs1_idx_o),
        .rs2_idx_o (rs2_idx_o)
    );

    id_ex_reg #(
        .XLEN (XLEN)
    ) i_id_ex_reg (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .instr_valid_i (instr_valid_i),
        .pc_i          (pc_i),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .instr_i       (instr_i),
        .ctrl_i        (dec_ctrl),
        .ctrl_o        (ex_ctrl),
        .ex_valid_o    (ex_valid_o),
        .ex_pc_o       (ex_pc),
        .ex_rs1_o      (ex_rs1),
        .ex_rs2_o      (ex_rs2),
        .ex_instr_o    (ex_instr)
    );

    ex_operand_unit #(
        .XLEN (XLEN)
    ) i_ex_operand_unit (
        .ctrl_i  (ex_ctrl),
        .instr_i (ex_instr),
        .pc_i    (ex_pc),
        .rs1_i   (ex_rs1),
        .rs2_i   (ex_rs2),
        .imm_o   (imm_o),
        .opnd1_o (opnd1_o),
        .opnd2_o (opnd2_o)
    );

    assign alu_op_o   = ex_ctrl.alu_op;
    assign rd_idx_o   = ex_ctrl.rd_idx;
    assign wb_en_o    = ex_ctrl.wb_en;
    assign is_jal_o   = ex_ctrl.is_jal;
    assign is_jalr_o  = ex_ctrl.is_jalr;
    assign is_brc_o   = ex_ctrl.is_brc;
    assign div_en_o   = ex_ctrl.div_en;
    assign div_sel_o  = ex_ctrl.div_sel;
    assign trap_o     = ex_ctrl.trap;
    assign trap_in_o  = ex_ctrl.trap_in;
    assign trap_out_o = ex_ctrl.trap_out;

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD     = 10,
    parameter int RST_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // release away from the rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// ==== dv/id_stage_tb.sv ====
`timescale 1ns/1ps

module id_stage_tb;

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    localparam int MAX_CYCLES = 400;

    // expected {is_jal, is_jalr, is_brc, trap, trap_in, trap_out}
    localparam logic [5:0] F_NONE = 6'b000000;
    localparam logic [5:0] F_JAL  = 6'b100000;
    localparam logic [5:0] F_JALR = 6'b010000;
    localparam logic [5:0] F_BRC  = 6'b001000;
    localparam logic [5:0] F_TRAP = 6'b000100;
    localparam logic [5:0] F_TIN  = 6'b000010;
    localparam logic [5:0] F_TOUT = 6'b000001;

    logic            clk;
    logic            rst_n;
    logic            instr_valid;
    logic [31:0]     instr;
    logic [63:0]     pc;
    logic [63:0]     rs1_data;
    logic [63:0]     rs2_data;
    logic            stall;
    logic            flush;
    logic [4:0]      rs1_idx;
    logic [4:0]      rs2_idx;
    logic            ex_valid;
    alu_op_e         alu_op;
    logic [63:0]     opnd1;
    logic [63:0]     opnd2;
    logic [63:0]     imm;
    logic [4:0]      rd_idx;
    logic            wb_en;
    logic            is_jal;
    logic            is_jalr;
    logic            is_brc;
    logic            div_en;
    div_sel_e        div_sel;
    logic            trap;
    logic            trap_in;
    logic            trap_out;

    integer          seed = 32'h98e52796;
    int              errors = 0;
    int              checks = 0;
    int              cycles = 0;
    logic [63:0]     exp_pc;
    logic [63:0]     exp_rs1;
    logic [63:0]     exp_rs2;

    tb_clk_gen #(.PERIOD(10), .RST_CYCLES(8)) i_tb_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    id_stage_top #(.XLEN(XLEN)) i_id_stage_top (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .pc_i          (pc),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .stall_i       (stall),
        .flush_i       (flush),
        .rs1_idx_o     (rs1_idx),
        .rs2_idx_o     (rs2_idx),
        .ex_valid_o    (ex_valid),
        .alu_op_o      (alu_op),
        .opnd1_o       (opnd1),
        .opnd2_o       (opnd2),
        .imm_o         (imm),
        .rd_idx_o      (rd_idx),
        .wb_en_o       (wb_en),
        .is_jal_o      (is_jal),
        .is_jalr_o     (is_jalr),
        .is_brc_o      (is_brc),
        .div_en_o      (div_en),
        .div_sel_o     (div_sel),
        .trap_o        (trap),
        .trap_in_o     (trap_in),
        .trap_out_o    (trap_out)
    );

    function automatic logic [31:0] rand32();
        logic [31:0] r;
        r = $random(seed);
        return r;
    endfunction

    // instruction encoders, low two bits always 11
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input opcode_e op);
        return {f7, rs2, rs1, f3, rd, op, 2'b11};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] im, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input opcode_e op);
        return {im, rs1, f3, rd, op, 2'b11};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] im, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {im[11:5], rs2, rs1, f3, im[4:0], OP_STORE, 2'b11};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] im, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {im[12], im[10:5], rs2, rs1, f3, im[4:1], im[11], OP_BRANCH, 2'b11};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] im, input logic [4:0] rd,
                                          input opcode_e op);
        return {im, rd, op, 2'b11};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] im, input logic [4:0] rd);
        return {im[20], im[10:1], im[11], im[19:12], rd, OP_JAL, 2'b11};
    endfunction

    function automatic logic [63:0] sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    // expected ALU op, alt is funct7 bit 5 where it applies
    function automatic alu_op_e ref_alu(input logic [2:0] f3, input logic alt,
                                        input logic word);
        alu_op_e op;
        case (f3)
            3'd0: op = alt ? (word ? ALU_SUB_32 : ALU_SUB_64) : (word ? ALU_ADD_32 : ALU_ADD_64);
            3'd1: op = word ? ALU_SLL_32 : ALU_SLL_64;
            3'd2: op = ALU_SLT;
            3'd3: op = ALU_SLTU;
            3'd4: op = ALU_XOR;
            3'd5: op = alt ? (word ? ALU_SRA_32 : ALU_SRA_64) : (word ? ALU_SRL_32 : ALU_SRL_64);
            3'd6: op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    task automatic expect_eq(input string name, input string field,
                             input logic [63:0] exp_v, input logic [63:0] act_v);
        checks++;
        assert (act_v === exp_v) else begin
            errors++;
            $display("error in %s, %s: expected %0h, actual %0h", name, field, exp_v, act_v);
        end
    endtask

    task automatic check_ctrl(input string name, input logic valid, input alu_op_e alu,
                              input logic wb, input logic [4:0] rd, input logic [5:0] flags);
        expect_eq(name, "ex_valid", 64'(valid), 64'(ex_valid));
        expect_eq(name, "alu_op", 64'(alu), 64'(alu_op));
        expect_eq(name, "wb_en", 64'(wb), 64'(wb_en));
        expect_eq(name, "rd_idx", 64'(rd), 64'(rd_idx));
        expect_eq(name, "flags", 64'(flags),
                  64'({is_jal, is_jalr, is_brc, trap, trap_in, trap_out}));
    endtask

    task automatic check_opnds(input string name, input logic [63:0] o1,
                               input logic [63:0] o2, input logic [63:0] im);
        expect_eq(name, "opnd1", o1, opnd1);
        expect_eq(name, "opnd2", o2, opnd2);
        expect_eq(name, "imm", im, imm);
    endtask

    // register indices leave the decoder without a clock
    task automatic check_idx(input string name, input logic [4:0] r1, input logic [4:0] r2);
        #1;
        expect_eq(name, "rs1_idx", 64'(r1), 64'(rs1_idx));
        expect_eq(name, "rs2_idx", 64'(r2), 64'(rs2_idx));
    endtask

    task automatic drive_instr(input logic [31:0] ins);
        exp_pc      = {rand32(), rand32()};
        exp_rs1     = {rand32(), rand32()};
        exp_rs2     = {rand32(), rand32()};
        instr_valid = 1'b1;
        instr       = ins;
        pc          = exp_pc;
        rs1_data    = exp_rs1;
        rs2_data    = exp_rs2;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic test_reset();
        // a valid jal offered while reset is low must not reach execute
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = enc_j(21'd8, 5'd1);
        @(negedge clk);
        check_ctrl("reset", 1'b0, ALU_ADD_64, 1'b0, 5'd0, F_NONE);
        instr_valid = 1'b0;
        instr       = 32'd0;

        @(posedge rst_n);
        @(negedge clk);
        check_ctrl("idle", 1'b0, ALU_ADD_64, 1'b0, 5'd0, F_NONE);
    endtask

    task automatic test_rtype();
        logic [31:0] r;
        logic [6:0]  f7;
        opcode_e     op;
        for (int o = 0; o < 2; o++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                for (int v = 0; v < 3; v++) begin
                    r  = rand32();
                    op = (o == 0) ? OP_REG : OP_REG_32;
                    // plain, alternate and M-extension forms
                    f7 = (v == 1) ? 7'h20 : ((v == 2) ? 7'h01 : 7'h00);
                    drive_instr(enc_r(f7, r[14:10], r[9:5], 3'(f3), r[4:0], op));
                    check_idx("rtype", r[9:5], r[14:10]);
                    next_cycle();
                    check_ctrl("rtype", 1'b1, ref_alu(3'(f3), f7[5], o == 1), 1'b1, r[4:0], F_NONE);
                    check_opnds("rtype", exp_rs1, exp_rs2, 64'd0);
                    expect_eq("rtype", "div_en", 64'(f7[0]), 64'(div_en));
                    expect_eq("rtype", "div_sel", 64'(f3), 64'(div_sel));
                end
            end
        end
    endtask

    task automatic test_imm_mem();
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] ins;
        logic [12:0] bim;
        logic        wb;
        for (int k = 0; k < 8; k++) begin
            r  = rand32();
            r2 = rand32();
            drive_instr(enc_i(r[11:0], r[16:12], r[24:22], r[21:17], r[25] ? OP_IMM_32 : OP_IMM));
            check_idx("itype", r[16:12], 5'd0);
            next_cycle();
            // only shifts right look at funct7 bit 5
            check_ctrl("itype", 1'b1, ref_alu(r[24:22], (r[24:22] == 3'd5) && r[10], r[25]),
                       1'b1, r[21:17], F_NONE);
            check_opnds("itype", exp_rs1, sext12(r[11:0]), sext12(r[11:0]));

            ins = enc_i(r[11:0], r[16:12], r[24:22], r[21:17], OP_LOAD);
            if (k[0]) begin
                ins[1:0] = 2'b01;
            end
            wb = !k[0];
            drive_instr(ins);
            check_idx("load", r[16:12], 5'd0);
            next_cycle();
            check_ctrl("load", 1'b1, ALU_ADD_64, wb, wb ? r[21:17] : 5'd0, F_NONE);
            check_opnds("load", exp_rs1, sext12(r[11:0]), sext12(r[11:0]));

            drive_instr(enc_s(r[11:0], r[30:26], r[16:12], r[24:22]));
            check_idx("store", r[16:12], r[30:26]);
            next_cycle();
            check_ctrl("store", 1'b1, ALU_ADD_64, 1'b0, 5'd0, F_NONE);
            check_opnds("store", exp_rs1, sext12(r[11:0]), sext12(r[11:0]));

            bim = {r2[11:0], 1'b0};
            drive_instr(enc_b(bim, r[30:26], r[16:12], r[24:22]));
            check_idx("branch", r[16:12], r[30:26]);
            next_cycle();
            check_ctrl("branch", 1'b1, ALU_ADD_64, 1'b0, 5'd0, F_BRC);
            check_opnds("branch", exp_rs1, exp_rs2, {{51{bim[12]}}, bim});
        end
    endtask

    task automatic test_jump_upper();
        logic [31:0] r;
        logic [63:0] uim;
        logic [20:0] jim;
        for (int k = 0; k < 4; k++) begin
            r   = rand32();
            jim = {r[31:12], 1'b0};
            uim = {{32{r[31]}}, r[31:12], 12'h000};
            drive_instr(enc_j(jim, r[4:0]));
            check_idx("jal", 5'd0, 5'd0);
            next_cycle();
            check_ctrl("jal", 1'b1, ALU_ADD_64, 1'b1, r[4:0], F_JAL);
            check_opnds("jal", exp_pc, 64'd4, {{43{jim[20]}}, jim});

            drive_instr(enc_i(r[31:20], r[9:5], 3'd0, r[4:0], OP_JALR));
            check_idx("jalr", r[9:5], 5'd0);
            next_cycle();
            check_ctrl("jalr", 1'b1, ALU_ADD_64, 1'b1, r[4:0], F_JALR);
            check_opnds("jalr", exp_pc, 64'd4, sext12(r[31:20]));

            drive_instr(enc_u(r[31:12], r[4:0], OP_LUI));
            check_idx("lui", 5'd0, 5'd0);
            next_cycle();
            check_ctrl("lui", 1'b1, ALU_SRC2, 1'b1, r[4:0], F_NONE);
            check_opnds("lui", exp_rs1, uim, uim);

            drive_instr(enc_u(r[31:12], r[4:0], OP_AUIPC));
            next_cycle();
            check_ctrl("auipc", 1'b1, ALU_ADD_64, 1'b1, r[4:0], F_NONE);
            check_opnds("auipc", exp_pc, uim, uim);
        end
    endtask

    task automatic sys_case(input string name, input logic [31:0] ins, input logic wb,
                            input logic [4:0] rd, input logic [5:0] flags);
        drive_instr(ins);
        next_cycle();
        check_ctrl(name, 1'b1, ALU_ADD_64, wb, rd, flags);
        check_opnds(name, exp_rs1, 64'd0, 64'd0);
    endtask

    task automatic test_system();
        logic [31:0] r;
        r = rand32();
        sys_case("ecall", enc_i(12'h000, 5'd0, 3'd0, 5'd0, OP_SYSTEM), 1'b0, 5'd0, F_TRAP | F_TIN);
        sys_case("ebreak", enc_i(12'h001, 5'd0, 3'd0, 5'd0, OP_SYSTEM), 1'b0, 5'd0, F_TRAP);
        sys_case("mret", enc_i(12'h302, 5'd0, 3'd0, 5'd0, OP_SYSTEM), 1'b0, 5'd0, F_TRAP | F_TOUT);
        sys_case("csrrw", enc_i(r[31:20], r[9:5], 3'd1, r[4:0], OP_SYSTEM), 1'b1, r[4:0], F_NONE);
        sys_case("csrrs", enc_i(r[31:20], r[9:5], 3'd2, r[4:0], OP_SYSTEM), 1'b1, r[4:0], F_NONE);

        // 01011 is not a decoded major opcode
        drive_instr({r[24:0], 5'b01011, 2'b11});
        next_cycle();
        check_ctrl("unknown", 1'b1, ALU_ADD_64, 1'b0, 5'd0, F_NONE);
        check_opnds("unknown", exp_rs1, exp_rs2, 64'd0);
    endtask

    task automatic test_stall_flush();
        logic [31:0] r;
        logic [63:0] held_rs1;
        r = rand32();
        drive_instr(enc_i(r[11:0], 5'd3, 3'd4, 5'd7, OP_IMM));
        next_cycle();
        held_rs1 = exp_rs1;
        check_ctrl("stall", 1'b1, ALU_XOR, 1'b1, 5'd7, F_NONE);

        // a new instruction arrives while execute is held
        stall = 1'b1;
        drive_instr(enc_u(r[31:12], 5'd9, OP_LUI));
        next_cycle();
        check_ctrl("stall", 1'b1, ALU_XOR, 1'b1, 5'd7, F_NONE);
        expect_eq("stall", "opnd1", held_rs1, opnd1);

        stall = 1'b0;
        next_cycle();
        check_ctrl("stall release", 1'b1, ALU_SRC2, 1'b1, 5'd9, F_NONE);
        expect_eq("stall release", "opnd1", exp_rs1, opnd1);

        stall = 1'b1;
        flush = 1'b1;
        next_cycle();
        expect_eq("flush over stall", "ex_valid", 64'd0, 64'(ex_valid));

        stall = 1'b0;
        flush = 1'b0;
        next_cycle();
        expect_eq("refill", "ex_valid", 64'd1, 64'(ex_valid));
        flush = 1'b1;
        next_cycle();
        expect_eq("flush", "ex_valid", 64'd0, 64'(ex_valid));
        flush       = 1'b0;
        instr_valid = 1'b0;
        next_cycle();
        expect_eq("idle", "ex_valid", 64'd0, 64'(ex_valid));
    endtask

    // guards against a hung run
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        instr_valid = 1'b0;
        instr       = 32'd0;
        pc          = 64'd0;
        rs1_data    = 64'd0;
        rs2_data    = 64'd0;
        stall       = 1'b0;
        flush       = 1'b0;
        exp_pc      = 64'd0;
        exp_rs1     = 64'd0;
        exp_rs2     = 64'd0;

        test_reset();
        test_rtype();
        test_imm_mem();
        test_jump_upper();
        test_system();
        test_stall_flush();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== build.f ====
src/rv_isa_pkg.sv
src/rv_ctrl_pkg.sv
src/id_ctrl_if.sv
src/id_decoder.sv
src/id_ex_reg.sv
src/ex_operand_unit.sv
src/id_stage_top.sv
dv/tb_clk_gen.sv
dv/id_stage_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile the decode stage with its testbench and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module id_stage_tb \
    -f build.f -Mdir obj_dir -o id_stage_sim \
    && ./obj_dir/id_stage_sim | tee /dev/stderr | grep -qx "No errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
